//--- source/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Byte address and block layout
`define ICACHE_ADDR_BITS 32
`define ICACHE_OFFSET_BITS 3

// Block tag is address bits 15:3, upper bits are always zero
`define ICACHE_TAG_BITS 13
`define ICACHE_BLOCK_BITS 64

// Line split between demand and stream capacity
`define ICACHE_DEMAND_LINES 12
`define ICACHE_STREAM_LINES 4

// Total lines, must stay a power of two for the victim LFSR
`define ICACHE_LINES (`ICACHE_DEMAND_LINES + `ICACHE_STREAM_LINES)

// Memory tag zero means no transaction
`define ICACHE_MEM_TAG_BITS 4

// Miss queue depth
`define ICACHE_MSHR_DEPTH 16

// Victim LFSR seed, must be nonzero
`define ICACHE_LFSR_SEED 4'h9

`endif

//--- source/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    // Byte address seen by fetch and memory
    typedef logic [`ICACHE_ADDR_BITS-1:0] i_addr_t;

    // Block tag, address bits above the block offset
    typedef logic [`ICACHE_TAG_BITS-1:0] i_tag_t;

    // One memory block of data
    typedef logic [`ICACHE_BLOCK_BITS-1:0] mem_block_t;

    // Memory transaction tag, zero means none
    typedef logic [`ICACHE_MEM_TAG_BITS-1:0] mem_tag_t;

    // Index of one line in the store
    typedef logic [$clog2(`ICACHE_LINES)-1:0] line_index_t;

endpackage

//--- source/evict_lfsr.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module evict_lfsr (
    input  logic                     clock,
    input  logic                     reset,
    output icache_pkg::line_index_t  index
);

    // Feedback mask for x^4 + x^3 + 1, maximal length
    localparam icache_pkg::line_index_t TAPS = 4'hC;

    icache_pkg::line_index_t state;

    // Galois form, shift right and fold the dropped bit back in
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= `ICACHE_LFSR_SEED;
        end else if (state[0]) begin
            state <= (state >> 1) ^ TAPS;
        end else begin
            state <= state >> 1;
        end
    end

    assign index = state;

endmodule

//--- source/icache_store.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_store (
    input  logic                    clock,
    input  logic                    reset,

    // Fetch reads, slot 0 is older
    input  logic                    read_valid_0,
    input  icache_pkg::i_tag_t      read_tag_0,
    input  logic                    read_valid_1,
    input  icache_pkg::i_tag_t      read_tag_1,
    output logic                    hit_0,
    output icache_pkg::mem_block_t  data_0,
    output logic                    hit_1,
    output icache_pkg::mem_block_t  data_1,

    // Request filter lookup
    input  logic                    snoop_valid,
    input  icache_pkg::i_tag_t      snoop_tag,
    output logic                    snoop_found,
    output logic                    full,

    // Line fill from the miss queue head
    input  logic                    fill_valid,
    input  icache_pkg::i_tag_t      fill_tag,
    input  icache_pkg::mem_block_t  fill_data
);

    localparam int LINES = `ICACHE_LINES;

    logic [LINES-1:0]        line_valid;
    icache_pkg::i_tag_t      line_tag  [LINES];
    icache_pkg::mem_block_t  line_data [LINES];

    logic [LINES-1:0]        match_0;
    logic [LINES-1:0]        match_1;
    logic [LINES-1:0]        match_snoop;

    icache_pkg::line_index_t victim_index;
    icache_pkg::line_index_t fill_index;

    evict_lfsr i_evict_lfsr (
        .clock (clock),
        .reset (reset),
        .index (victim_index)
    );

    // Every line is compared against both reads and the snoop
    for (genvar i = 0; i < LINES; i++) begin : g_compare
        assign match_0[i]     = read_valid_0 & line_valid[i] & (line_tag[i] == read_tag_0);
        assign match_1[i]     = read_valid_1 & line_valid[i] & (line_tag[i] == read_tag_1);
        assign match_snoop[i] = snoop_valid & line_valid[i] & (line_tag[i] == snoop_tag);
    end

    assign hit_0       = |match_0;
    assign hit_1       = |match_1;
    assign snoop_found = |match_snoop;
    assign full        = &line_valid;

    // At most one line matches, so OR-ing masked data is a mux
    always_comb begin
        data_0 = '0;
        data_1 = '0;
        for (int i = 0; i < LINES; i++) begin
            if (match_0[i]) begin
                data_0 = data_0 | line_data[i];
            end
            if (match_1[i]) begin
                data_1 = data_1 | line_data[i];
            end
        end
    end

    // Lowest free line wins, random victim once everything is valid
    always_comb begin
        fill_index = victim_index;
        for (int i = LINES - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                fill_index = icache_pkg::line_index_t'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_valid) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= fill_data;
        end
    end

endmodule

//--- source/miss_queue.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module miss_queue #(
    parameter int DEPTH = `ICACHE_MSHR_DEPTH
) (
    input  logic                  clock,
    input  logic                  reset,

    // Request filter lookup
    input  icache_pkg::i_tag_t    snoop_tag,
    output logic                  snoop_found,

    // Accepted memory request
    input  logic                  push_valid,
    input  icache_pkg::i_tag_t    push_block_tag,
    input  icache_pkg::mem_tag_t  push_mem_tag,

    // Returned data tag and resulting fill
    input  icache_pkg::mem_tag_t  mem_data_tag,
    output logic                  fill_valid,
    output icache_pkg::i_tag_t    fill_tag
);

    localparam int PTR_BITS = $clog2(DEPTH);

    logic [DEPTH-1:0]       entry_valid;
    icache_pkg::i_tag_t     entry_block_tag [DEPTH];
    icache_pkg::mem_tag_t   entry_mem_tag   [DEPTH];

    logic [PTR_BITS-1:0]    head;
    logic [PTR_BITS-1:0]    tail;
    logic [DEPTH-1:0]       snoop_hits;
    logic                   pop;

    // Only live entries count as in flight
    for (genvar i = 0; i < DEPTH; i++) begin : g_snoop
        assign snoop_hits[i] = entry_valid[i] & (entry_block_tag[i] == snoop_tag);
    end
    assign snoop_found = |snoop_hits;

    // Tags come back in issue order, so only the head can match
    assign pop = (mem_data_tag != '0) & entry_valid[head] & (mem_data_tag == entry_mem_tag[head]);

    assign fill_valid = pop;
    assign fill_tag   = pop ? entry_block_tag[head] : '0;

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            entry_valid <= '0;
        end else begin
            if (pop) begin
                entry_valid[head] <= 1'b0;
                head              <= head + PTR_BITS'(1);
            end
            if (push_valid) begin
                entry_valid[tail] <= 1'b1;
                tail              <= tail + PTR_BITS'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push_valid) begin
            entry_block_tag[tail] <= push_block_tag;
            entry_mem_tag[tail]   <= push_mem_tag;
        end
    end

endmodule

//--- source/stream_prefetcher.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module stream_prefetcher (
    input  logic                 clock,
    input  logic                 reset,

    // Oldest demand miss, block aligned
    input  logic                 miss_valid,
    input  icache_pkg::i_addr_t  miss_addr,

    input  logic                 cache_full,
    input  logic                 mem_req_accepted,

    // Request candidate for the filter
    output logic                 cand_valid,
    output icache_pkg::i_addr_t  cand_addr
);

    localparam icache_pkg::i_addr_t BLOCK_STRIDE = 1 << `ICACHE_OFFSET_BITS;

    logic                 stream_valid;
    icache_pkg::i_addr_t  last_demand;
    icache_pkg::i_addr_t  stream_base;
    icache_pkg::i_addr_t  next_block;
    logic                 new_miss;

    assign next_block = stream_base + BLOCK_STRIDE;

    // A miss is new until its block has been accepted once
    assign new_miss = miss_valid & (!stream_valid | (miss_addr != last_demand));

    always_comb begin
        cand_valid = 1'b0;
        cand_addr  = '0;
        if (new_miss) begin
            cand_valid = 1'b1;
            cand_addr  = miss_addr;
        end else if (stream_valid && !cache_full) begin
            cand_valid = 1'b1;
            cand_addr  = next_block;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stream_valid <= 1'b0;
            last_demand  <= '0;
            stream_base  <= '0;
        end else if (mem_req_accepted && new_miss) begin
            // Restart the stream at the demand block
            stream_valid <= 1'b1;
            last_demand  <= miss_addr;
            stream_base  <= miss_addr;
        end else if (mem_req_accepted && cand_valid) begin
            stream_base <= next_block;
        end
    end

endmodule

//--- source/icache_subsystem.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_subsystem (
    input  logic                    clock,
    input  logic                    reset,

    // Fetch, slot 0 is older
    input  logic                    read_valid_0,
    input  icache_pkg::i_addr_t     read_addr_0,
    input  logic                    read_valid_1,
    input  icache_pkg::i_addr_t     read_addr_1,
    output logic                    hit_0,
    output icache_pkg::mem_block_t  data_0,
    output logic                    hit_1,
    output icache_pkg::mem_block_t  data_1,

    // Memory
    output logic                    mem_req_valid,
    output icache_pkg::i_addr_t     mem_req_addr,
    input  logic                    mem_req_accepted,
    input  icache_pkg::mem_tag_t    current_req_tag,
    input  icache_pkg::mem_block_t  mem_data,
    input  icache_pkg::mem_tag_t    mem_data_tag
);

    icache_pkg::i_tag_t   read_tag_0;
    icache_pkg::i_tag_t   read_tag_1;
    icache_pkg::i_tag_t   cand_tag;
    icache_pkg::i_tag_t   fill_tag;
    icache_pkg::i_addr_t  miss_addr;
    icache_pkg::i_addr_t  cand_addr;
    logic                 miss_valid;
    logic                 cand_valid;
    logic                 cand_in_cache;
    logic                 cand_in_flight;
    logic                 cache_full;
    logic                 fill_valid;
    logic                 req_taken;

    assign read_tag_0 = read_addr_0[`ICACHE_OFFSET_BITS +: `ICACHE_TAG_BITS];
    assign read_tag_1 = read_addr_1[`ICACHE_OFFSET_BITS +: `ICACHE_TAG_BITS];
    assign cand_tag   = cand_addr[`ICACHE_OFFSET_BITS +: `ICACHE_TAG_BITS];

    // Oldest missing slot becomes the demand miss, block aligned
    always_comb begin
        miss_valid = 1'b0;
        miss_addr  = '0;
        if (read_valid_0 && !hit_0) begin
            miss_valid = 1'b1;
            miss_addr  = {read_addr_0[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                          {`ICACHE_OFFSET_BITS{1'b0}}};
        end else if (read_valid_1 && !hit_1) begin
            miss_valid = 1'b1;
            miss_addr  = {read_addr_1[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                          {`ICACHE_OFFSET_BITS{1'b0}}};
        end
    end

    // Drop candidates that are cached or already in flight
    assign mem_req_valid = cand_valid & ~cand_in_cache & ~cand_in_flight;
    assign mem_req_addr  = cand_addr;
    assign req_taken     = mem_req_valid & mem_req_accepted;

    icache_store i_store (
        .clock        (clock),
        .reset        (reset),
        .read_valid_0 (read_valid_0),
        .read_tag_0   (read_tag_0),
        .read_valid_1 (read_valid_1),
        .read_tag_1   (read_tag_1),
        .hit_0        (hit_0),
        .data_0       (data_0),
        .hit_1        (hit_1),
        .data_1       (data_1),
        .snoop_valid  (cand_valid),
        .snoop_tag    (cand_tag),
        .snoop_found  (cand_in_cache),
        .full         (cache_full),
        .fill_valid   (fill_valid),
        .fill_tag     (fill_tag),
        .fill_data    (mem_data)
    );

    miss_queue i_miss_queue (
        .clock          (clock),
        .reset          (reset),
        .snoop_tag      (cand_tag),
        .snoop_found    (cand_in_flight),
        .push_valid     (req_taken),
        .push_block_tag (cand_tag),
        .push_mem_tag   (current_req_tag),
        .mem_data_tag   (mem_data_tag),
        .fill_valid     (fill_valid),
        .fill_tag       (fill_tag)
    );

    stream_prefetcher i_prefetcher (
        .clock            (clock),
        .reset            (reset),
        .miss_valid       (miss_valid),
        .miss_addr        (miss_addr),
        .cache_full       (cache_full),
        .mem_req_accepted (req_taken),
        .cand_valid       (cand_valid),
        .cand_addr        (cand_addr)
    );

endmodule

//--- dv/icache_subsystem_sva.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_subsystem_sva (
    input logic                  clock,
    input logic                  reset,
    input logic                  hit_0,
    input logic                  hit_1,
    input logic                  mem_req_valid,
    input logic                  mem_req_accepted,
    input icache_pkg::mem_tag_t  current_req_tag,
    input icache_pkg::mem_tag_t  mem_data_tag,
    input logic                  fill_valid
);

    // Memory tags taken by the DUT and not yet returned
    logic [(1 << `ICACHE_MEM_TAG_BITS)-1:0] tag_pending;

    always_ff @(posedge clock) begin
        if (reset) begin
            tag_pending <= '0;
        end else begin
            if (mem_data_tag != '0) begin
                tag_pending[mem_data_tag] <= 1'b0;
            end
            if (mem_req_valid && mem_req_accepted) begin
                tag_pending[current_req_tag] <= 1'b1;
            end
        end
    end

    quiet_in_reset: assert property (@(posedge clock)
        reset |-> !mem_req_valid && !hit_0 && !hit_1)
        else $error("Request or hit during reset");

    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !mem_req_valid && !hit_0 && !hit_1)
        else $error("Request or hit right after reset");

    // Queue holds exactly the accepted requests, so every return pops the head
    return_pops_head: assert property (@(posedge clock) disable iff (reset)
        (mem_data_tag != '0) |-> fill_valid)
        else $error("Returned tag does not match the miss queue head");

    return_tag_known: assert property (@(posedge clock) disable iff (reset)
        (mem_data_tag != '0) |-> tag_pending[mem_data_tag])
        else $error("Returned tag matches no outstanding request");

endmodule

bind icache_subsystem icache_subsystem_sva i_sva (
    .clock            (clock),
    .reset            (reset),
    .hit_0            (hit_0),
    .hit_1            (hit_1),
    .mem_req_valid    (mem_req_valid),
    .mem_req_accepted (mem_req_accepted),
    .current_req_tag  (current_req_tag),
    .mem_data_tag     (mem_data_tag),
    .fill_valid       (fill_valid)
);

//--- dv/icache_subsystem_tb.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_subsystem_tb;

    localparam int RUN_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;
    localparam int LINES          = `ICACHE_LINES;
    localparam int BLOCK_BYTES    = 1 << `ICACHE_OFFSET_BITS;
    localparam int BLOCK_COUNT    = 1 << `ICACHE_TAG_BITS;
    localparam int WINDOW_BASE    = 32'h0000_2000;
    localparam int WINDOW_BLOCKS  = 24;
    localparam int RETURN_LATENCY = 6;
    localparam int HOLD_PERIOD    = 250;
    localparam int HOLD_LENGTH    = 50;

    logic                    clock;
    logic                    reset;
    logic                    read_valid_0;
    icache_pkg::i_addr_t     read_addr_0;
    logic                    read_valid_1;
    icache_pkg::i_addr_t     read_addr_1;
    logic                    hit_0;
    icache_pkg::mem_block_t  data_0;
    logic                    hit_1;
    icache_pkg::mem_block_t  data_1;
    logic                    mem_req_valid;
    icache_pkg::i_addr_t     mem_req_addr;
    logic                    mem_req_accepted;
    icache_pkg::mem_tag_t    current_req_tag;
    icache_pkg::mem_block_t  mem_data;
    icache_pkg::mem_tag_t    mem_data_tag;

    // Memory model and bookkeeping
    logic [31:0]             rng;
    icache_pkg::mem_tag_t    next_tag;
    int                      cycle;
    int                      elapsed = 0;
    int                      fill_count;
    bit                      outstanding   [BLOCK_COUNT];
    bit                      resident      [BLOCK_COUNT];
    bit                      ever_accepted [BLOCK_COUNT];
    int                      ret_cycle [$];
    icache_pkg::i_tag_t      ret_blk   [$];
    icache_pkg::mem_tag_t    ret_tag   [$];
    logic                    returning;
    icache_pkg::i_tag_t      returning_blk;
    logic                    holding;
    logic                    stream_armed;
    icache_pkg::i_addr_t     stream_prev;

    icache_subsystem i_dut (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Block tag repeated in 16-bit fields, then scrambled
    function automatic icache_pkg::mem_block_t block_pattern(input icache_pkg::i_tag_t blk);
        logic [15:0] field;
        field = {3'b000, blk};
        return {4{field}} ^ 64'hA5A5_0000_5A5A_FFFF;
    endfunction

    function automatic icache_pkg::i_tag_t block_of(input icache_pkg::i_addr_t addr);
        return addr[`ICACHE_OFFSET_BITS +: `ICACHE_TAG_BITS];
    endfunction

    function automatic icache_pkg::i_addr_t fetch_addr(input int blk, input logic upper_word);
        int byte_addr;
        byte_addr = WINDOW_BASE + blk * BLOCK_BYTES;
        if (upper_word) begin
            byte_addr = byte_addr + 4;
        end
        return icache_pkg::i_addr_t'(byte_addr);
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string test, input icache_pkg::mem_block_t expected,
                                   input icache_pkg::mem_block_t actual);
        stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", test, expected, actual));
    endtask

    task automatic drive_cycle();
        int blk;
        holding = (cycle % HOLD_PERIOD) < HOLD_LENGTH;
        if (cycle % HOLD_PERIOD == 0) begin
            stream_armed = 1'b0;
        end
        rng = xorshift(rng);
        mem_req_accepted = (rng[1:0] != 2'b00);
        current_req_tag  = next_tag;
        if (holding) begin
            // Both slots sit in one block so no second miss appears
            blk = (10 + 7 * (cycle / HOLD_PERIOD)) % WINDOW_BLOCKS;
            read_valid_0 = 1'b1;
            read_addr_0  = fetch_addr(blk, 1'b0);
            read_valid_1 = 1'b1;
            read_addr_1  = fetch_addr(blk, 1'b1);
        end else begin
            rng = xorshift(rng);
            read_valid_0 = (rng[31:29] != 3'b000);
            read_addr_0  = fetch_addr(int'(rng % WINDOW_BLOCKS), rng[28]);
            rng = xorshift(rng);
            read_valid_1 = (rng[31:29] != 3'b000);
            read_addr_1  = fetch_addr(int'(rng % WINDOW_BLOCKS), rng[28]);
        end
        // In-order return at a fixed latency
        returning = (ret_cycle.size() > 0) && (ret_cycle[0] == cycle);
        if (returning) begin
            void'(ret_cycle.pop_front());
            returning_blk = ret_blk.pop_front();
            mem_data_tag  = ret_tag.pop_front();
            mem_data      = block_pattern(returning_blk);
        end else begin
            mem_data_tag = '0;
            mem_data     = '0;
        end
    endtask

    task automatic check_cycle();
        icache_pkg::i_tag_t   tag0;
        icache_pkg::i_tag_t   tag1;
        icache_pkg::i_tag_t   req_blk;
        icache_pkg::i_addr_t  expected_addr;
        logic                 expected_hit;
        tag0    = block_of(read_addr_0);
        tag1    = block_of(read_addr_1);
        req_blk = block_of(mem_req_addr);
        // Before the first eviction the model knows every cached block
        if (fill_count <= LINES) begin
            expected_hit = read_valid_0 && resident[tag0];
            assert (hit_0 == expected_hit)
                else report_mismatch("hit_flag_0", 64'(expected_hit), 64'(hit_0));
            expected_hit = read_valid_1 && resident[tag1];
            assert (hit_1 == expected_hit)
                else report_mismatch("hit_flag_1", 64'(expected_hit), 64'(hit_1));
        end
        if (hit_0) begin
            assert (data_0 == block_pattern(tag0))
                else report_mismatch("hit_data_0", block_pattern(tag0), data_0);
        end else begin
            assert (data_0 == '0)
                else report_mismatch("miss_data_0", '0, data_0);
        end
        if (hit_1) begin
            assert (data_1 == block_pattern(tag1))
                else report_mismatch("hit_data_1", block_pattern(tag1), data_1);
        end else begin
            assert (data_1 == '0)
                else report_mismatch("miss_data_1", '0, data_1);
        end
        // A block never taken by memory is neither cached nor in flight
        if (read_valid_0 && !hit_0 && !ever_accepted[tag0]) begin
            expected_addr = read_addr_0 & ~icache_pkg::i_addr_t'(BLOCK_BYTES - 1);
            assert (mem_req_valid)
                else stop_with_failure("Slot 0 missed a new block but no request went out");
            assert (mem_req_addr == expected_addr)
                else report_mismatch("slot0_priority", 64'(expected_addr), 64'(mem_req_addr));
        end
        if (mem_req_valid) begin
            assert (!outstanding[req_blk])
                else stop_with_failure("Block requested again while still in flight");
            // Residency is only known until the first eviction
            if (fill_count <= LINES) begin
                assert (!resident[req_blk])
                    else stop_with_failure("Block requested although it is already cached");
            end
        end
        if (holding && mem_req_valid && mem_req_accepted && fill_count <= LINES) begin
            if (stream_armed) begin
                expected_addr = stream_prev + icache_pkg::i_addr_t'(BLOCK_BYTES);
                assert (mem_req_addr == expected_addr)
                    else report_mismatch("stream_sequence", 64'(expected_addr),
                                         64'(mem_req_addr));
            end
            stream_armed = 1'b1;
            stream_prev  = mem_req_addr;
        end
    endtask

    task automatic update_model();
        icache_pkg::i_tag_t req_blk;
        req_blk = block_of(mem_req_addr);
        if (returning) begin
            outstanding[returning_blk] = 1'b0;
            resident[returning_blk]    = 1'b1;
            fill_count = fill_count + 1;
        end
        if (mem_req_valid && mem_req_accepted) begin
            outstanding[req_blk]   = 1'b1;
            ever_accepted[req_blk] = 1'b1;
            ret_cycle.push_back(cycle + RETURN_LATENCY);
            ret_blk.push_back(req_blk);
            ret_tag.push_back(next_tag);
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
    endtask

    always @(posedge clock) begin
        elapsed = elapsed + 1;
        if (elapsed > TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        read_valid_0     = 1'b0;
        read_addr_0      = '0;
        read_valid_1     = 1'b0;
        read_addr_1      = '0;
        mem_req_accepted = 1'b0;
        current_req_tag  = 4'd1;
        mem_data         = '0;
        mem_data_tag     = '0;
        rng              = 32'h2c5a_df38;
        next_tag         = 4'd1;
        fill_count       = 0;
        returning        = 1'b0;
        returning_blk    = '0;
        holding          = 1'b0;
        stream_armed     = 1'b0;
        stream_prev      = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        // One idle cycle after reset before fetch starts
        for (cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            @(posedge clock);
            #1;
            drive_cycle();
            @(negedge clock);
            check_cycle();
            update_model();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/icache_pkg.sv
source/evict_lfsr.sv
source/icache_store.sv
source/miss_queue.sv
source/stream_prefetcher.sv
source/icache_subsystem.sv
dv/icache_subsystem_sva.sv
dv/icache_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= icache_subsystem_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
